// File: Bender.yml
package:
  name: issue_read_operands

export_include_dirs:
  - common

sources:
  - common/issue_pkg.sv
  - hw/issue/issue_hazard_check.sv
  - hw/issue/int_regfile.sv
  - hw/issue/operand_select.sv
  - hw/issue/issue_dispatch_reg.sv
  - hw/issue/issue_read_operands.sv

  - target: test
    files:
      - bench/tb_issue_read_operands.sv

// File: bench/tb_issue_read_operands.sv
/*
 * testbench for the integer issue and read operands stage
 * table of instructions with a register file model and expected acks and valids
 */
`timescale 1ns/1ns
`include "issue_cfg.svh"

module tb_issue_read_operands;

    // short unit names for the table
    localparam issue_pkg::fu_t fu_n   = issue_pkg::NONE;
    localparam issue_pkg::fu_t fu_ld  = issue_pkg::LOAD;
    localparam issue_pkg::fu_t fu_st  = issue_pkg::STORE;
    localparam issue_pkg::fu_t fu_alu = issue_pkg::ALU;
    localparam issue_pkg::fu_t fu_br  = issue_pkg::CTRL_FLOW;
    localparam issue_pkg::fu_t fu_mul = issue_pkg::MULT;
    localparam issue_pkg::fu_t fu_csr = issue_pkg::CSR;

    typedef struct packed {
        issue_pkg::fu_t       fu;
        issue_pkg::reg_addr_t rs1;
        issue_pkg::reg_addr_t rs2;
        issue_pkg::reg_addr_t rd;
        // valid, use_imm, use_pc, use_zimm, ex_valid
        logic [4:0]           flags;
        // one clobbered register and the unit that writes it
        issue_pkg::fu_t       cfu;
        issue_pkg::reg_addr_t creg;
        // rs1_valid, rs2_valid
        logic [1:0]           fwd_v;
        // flu_ready, lsu_ready, flush
        logic [2:0]           ctl;
        logic [1:0]           we;
        issue_pkg::reg_addr_t wa0;
        issue_pkg::reg_addr_t wa1;
        logic                 exp_ack;
        // alu, branch, lsu, mult, csr
        logic [4:0]           exp_v;
    } row_t;

    logic                    clk_i;
    logic                    rst_ni;
    logic                    flush_i;
    logic                    issue_valid_i;
    issue_pkg::fu_t          issue_fu_i;
    issue_pkg::fu_op_t       issue_op_i;
    issue_pkg::reg_addr_t    issue_rs1_i;
    issue_pkg::reg_addr_t    issue_rs2_i;
    issue_pkg::reg_addr_t    issue_rd_i;
    issue_pkg::data_t        issue_imm_i;
    issue_pkg::data_t        issue_pc_i;
    issue_pkg::trans_id_t    issue_trans_id_i;
    logic                    issue_use_imm_i;
    logic                    issue_use_pc_i;
    logic                    issue_use_zimm_i;
    logic                    issue_ex_valid_i;
    logic                    issue_ack_o;
    issue_pkg::clobber_t     rd_clobber_i;
    issue_pkg::data_t        rs1_i;
    logic                    rs1_valid_i;
    issue_pkg::data_t        rs2_i;
    logic                    rs2_valid_i;
    logic                    flu_ready_i;
    logic                    lsu_ready_i;
    issue_pkg::data_t        operand_a_o;
    issue_pkg::data_t        operand_b_o;
    issue_pkg::data_t        imm_o;
    issue_pkg::fu_t          fu_o;
    issue_pkg::fu_op_t       operator_o;
    issue_pkg::trans_id_t    trans_id_o;
    issue_pkg::data_t        pc_o;
    logic                    alu_valid_o;
    logic                    branch_valid_o;
    logic                    lsu_valid_o;
    logic                    mult_valid_o;
    logic                    csr_valid_o;
    issue_pkg::commit_addr_t waddr_i;
    issue_pkg::commit_data_t wdata_i;
    issue_pkg::commit_we_t   we_i;

    row_t             tbl [$];
    issue_pkg::data_t model_regs [`ISSUE_NR_REGS];
    issue_pkg::data_t exp_a [64];
    issue_pkg::data_t exp_b [64];
    issue_pkg::data_t wd0 [64];
    issue_pkg::data_t wd1 [64];
    int               errors;
    int               cycles;
    int               limit_cycles;
    int unsigned      seed_val;

    issue_read_operands u_dut (.*);

    always #50 clk_i = ~clk_i;

    // run limit from the table length
    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (limit_cycles > 0 && cycles >= limit_cycles) begin
            $display("timeout, run did not end within %0d cycles", limit_cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // per row stimulus values
    // ------------------------------------------------------------------------
    function automatic issue_pkg::data_t imm_of(input int k);
        return 64'hffff_f000_0000_0000 | issue_pkg::data_t'(k);
    endfunction

    function automatic issue_pkg::data_t pc_of(input int k);
        return 64'h0000_0000_8000_0000 + issue_pkg::data_t'(4 * k);
    endfunction

    // scoreboard values for rs1 and rs2
    function automatic issue_pkg::data_t fwd_a_of(input int k);
        return 64'ha5a5_0000_0000_0000 | issue_pkg::data_t'(k);
    endfunction

    function automatic issue_pkg::data_t fwd_b_of(input int k);
        return 64'h5a5a_0000_0000_0000 | issue_pkg::data_t'(k);
    endfunction

    task automatic add_row(input issue_pkg::fu_t fu, input int rs1, input int rs2, input int rd,
                           input logic [4:0] flags, input issue_pkg::fu_t cfu, input int creg,
                           input logic [1:0] fwd_v, input logic [2:0] ctl, input logic [1:0] we,
                           input int wa0, input int wa1, input int exp_ack,
                           input logic [4:0] exp_v);
        tbl.push_back('{fu, rs1[4:0], rs2[4:0], rd[4:0], flags, cfu, creg[4:0], fwd_v, ctl,
                        we, wa0[4:0], wa1[4:0], exp_ack != 0, exp_v});
    endtask

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------
    task automatic check_data(input string name, input int row, input issue_pkg::data_t got,
                              input issue_pkg::data_t exp);
        if (got !== exp) begin
            $display("Fail %s row %0d: got %h expected %h", name, row, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic check_fu(input string name, input int row, input issue_pkg::fu_t got,
                            input issue_pkg::fu_t exp);
        if (got !== exp) begin
            $display("Fail %s row %0d: got %h expected %h", name, row, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic check_bit(input string name, input int row, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s row %0d: got %h expected %h", name, row, got, exp);
            errors = errors + 1;
        end
    endtask

    // ------------------------------------------------------------------------
    // drive, model and check
    // ------------------------------------------------------------------------
    task automatic drive_row(input int k);
        row_t r;
        r = tbl[k];
        issue_valid_i    = r.flags[4];
        issue_use_imm_i  = r.flags[3];
        issue_use_pc_i   = r.flags[2];
        issue_use_zimm_i = r.flags[1];
        issue_ex_valid_i = r.flags[0];
        issue_fu_i       = r.fu;
        issue_op_i       = issue_pkg::fu_op_t'(8'(k % 10));
        issue_rs1_i      = r.rs1;
        issue_rs2_i      = r.rs2;
        issue_rd_i       = r.rd;
        issue_imm_i      = imm_of(k);
        issue_pc_i       = pc_of(k);
        issue_trans_id_i = k[2:0];
        for (int i = 0; i < `ISSUE_NR_REGS; i++) begin
            rd_clobber_i[i] = issue_pkg::NONE;
        end
        rd_clobber_i[r.creg] = r.cfu;
        rs1_i       = fwd_a_of(k);
        rs2_i       = fwd_b_of(k);
        rs1_valid_i = r.fwd_v[1];
        rs2_valid_i = r.fwd_v[0];
        flu_ready_i = r.ctl[2];
        lsu_ready_i = r.ctl[1];
        flush_i     = r.ctl[0];
        // commit data is random, addresses come from the row
        wd0[k]     = {$urandom, $urandom};
        wd1[k]     = {$urandom, $urandom};
        we_i       = r.we;
        waddr_i[0] = r.wa0;
        waddr_i[1] = r.wa1;
        wdata_i[0] = wd0[k];
        wdata_i[1] = wd1[k];
    endtask

    // expected operands from the register model and the selection rules
    task automatic expect_row(input int k);
        row_t             r;
        issue_pkg::data_t src_a;
        issue_pkg::data_t src_b;
        r     = tbl[k];
        src_a = model_regs[r.rs1];
        src_b = model_regs[r.rs2];
        // csr results never come from the scoreboard
        if (r.cfu != issue_pkg::NONE && r.cfu != issue_pkg::CSR) begin
            if (r.creg == r.rs1 && r.fwd_v[1]) begin
                src_a = fwd_a_of(k);
            end
            if (r.creg == r.rs2 && r.fwd_v[0]) begin
                src_b = fwd_b_of(k);
            end
        end
        if (r.flags[1]) begin
            exp_a[k] = issue_pkg::data_t'(r.rs1);
        end else if (r.flags[2]) begin
            exp_a[k] = pc_of(k);
        end else begin
            exp_a[k] = src_a;
        end
        exp_b[k] = src_b;
        if (r.flags[3] && r.fu != issue_pkg::STORE && r.fu != issue_pkg::CTRL_FLOW) begin
            exp_b[k] = imm_of(k);
        end
    endtask

    // register writes land at the edge, port 1 after port 0
    task automatic apply_commit(input int k);
        if (tbl[k].we[0] && tbl[k].wa0 != '0) begin
            model_regs[tbl[k].wa0] = wd0[k];
        end
        if (tbl[k].we[1] && tbl[k].wa1 != '0) begin
            model_regs[tbl[k].wa1] = wd1[k];
        end
    endtask

    task automatic check_row(input int k);
        row_t r;
        r = tbl[k];
        check_bit("alu_valid_o", k, alu_valid_o, r.exp_v[4]);
        check_bit("branch_valid_o", k, branch_valid_o, r.exp_v[3]);
        check_bit("lsu_valid_o", k, lsu_valid_o, r.exp_v[2]);
        check_bit("mult_valid_o", k, mult_valid_o, r.exp_v[1]);
        check_bit("csr_valid_o", k, csr_valid_o, r.exp_v[0]);
        if (r.exp_ack) begin
            check_data("operand_a_o", k, operand_a_o, exp_a[k]);
            check_data("operand_b_o", k, operand_b_o, exp_b[k]);
            check_data("imm_o", k, imm_o, imm_of(k));
            check_data("pc_o", k, pc_o, pc_of(k));
            check_data("trans_id_o", k, issue_pkg::data_t'(trans_id_o),
                       issue_pkg::data_t'(k % 8));
            check_data("operator_o", k, issue_pkg::data_t'(operator_o),
                       issue_pkg::data_t'(k % 10));
            check_fu("fu_o", k, fu_o, r.fu);
        end
    endtask

    initial begin
        errors       = 0;
        cycles       = 0;
        limit_cycles = 0;
        seed_val     = $urandom(79);
        clk_i        = 1'b0;
        rst_ni       = 1'b0;
        for (int i = 0; i < `ISSUE_NR_REGS; i++) begin
            model_regs[i] = '0;
        end

        // fu rs1 rs2 rd flags cfu creg fwd_v ctl we wa0 wa1 ack valids
        // register read, commit port priority, x0
        add_row(fu_n, 0, 0, 0, 5'b10000, fu_n, 0, 2'b00, 3'b110, 2'b11, 1, 2, 1, 5'b00000);
        add_row(fu_alu, 1, 2, 3, 5'b10000, fu_n, 0, 2'b00, 3'b110, 2'b00, 0, 0, 1, 5'b10000);
        add_row(fu_n, 0, 0, 0, 5'b10000, fu_n, 0, 2'b00, 3'b110, 2'b11, 5, 5, 1, 5'b00000);
        add_row(fu_alu, 5, 0, 4, 5'b10000, fu_n, 0, 2'b00, 3'b110, 2'b01, 0, 0, 1, 5'b10000);
        add_row(fu_alu, 0, 5, 4, 5'b10000, fu_n, 0, 2'b00, 3'b110, 2'b00, 0, 0, 1, 5'b10000);
        // forwarding and stalls
        add_row(fu_alu, 1, 2, 3, 5'b10000, fu_alu, 1, 2'b10, 3'b110, 2'b00, 0, 0, 1, 5'b10000);
        add_row(fu_alu, 3, 2, 4, 5'b10000, fu_ld, 2, 2'b01, 3'b110, 2'b00, 0, 0, 1, 5'b10000);
        add_row(fu_alu, 1, 2, 3, 5'b10000, fu_alu, 1, 2'b00, 3'b110, 2'b00, 0, 0, 0, 5'b00000);
        add_row(fu_alu, 1, 2, 3, 5'b10000, fu_csr, 1, 2'b10, 3'b110, 2'b00, 0, 0, 0, 5'b00000);
        // operand selection and routing
        add_row(fu_alu, 1, 2, 3, 5'b10100, fu_alu, 1, 2'b10, 3'b110, 2'b00, 0, 0, 1, 5'b10000);
        add_row(fu_csr, 19, 0, 6, 5'b10110, fu_csr, 19, 2'b00, 3'b110, 2'b00, 0, 0, 1, 5'b00001);
        add_row(fu_alu, 1, 2, 3, 5'b11000, fu_n, 0, 2'b00, 3'b110, 2'b00, 0, 0, 1, 5'b10000);
        add_row(fu_st, 1, 2, 0, 5'b11000, fu_n, 0, 2'b00, 3'b110, 2'b00, 0, 0, 1, 5'b00100);
        add_row(fu_br, 1, 2, 0, 5'b11000, fu_n, 0, 2'b00, 3'b110, 2'b00, 0, 0, 1, 5'b01000);
        add_row(fu_ld, 1, 2, 9, 5'b11000, fu_n, 0, 2'b00, 3'b110, 2'b00, 0, 0, 1, 5'b00100);
        // WAW, back-pressure, exceptions and unit-less instructions
        add_row(fu_alu, 1, 2, 7, 5'b10000, fu_mul, 7, 2'b00, 3'b110, 2'b00, 0, 0, 0, 5'b00000);
        add_row(fu_alu, 1, 2, 7, 5'b10000, fu_mul, 7, 2'b00, 3'b110, 2'b10, 0, 7, 1, 5'b10000);
        add_row(fu_alu, 1, 2, 3, 5'b10000, fu_n, 0, 2'b00, 3'b010, 2'b00, 0, 0, 0, 5'b00000);
        add_row(fu_ld, 1, 2, 3, 5'b10000, fu_n, 0, 2'b00, 3'b100, 2'b00, 0, 0, 0, 5'b00000);
        add_row(fu_alu, 1, 2, 3, 5'b10001, fu_n, 0, 2'b00, 3'b000, 2'b00, 0, 0, 1, 5'b00000);
        add_row(fu_n, 1, 2, 3, 5'b10000, fu_n, 0, 2'b00, 3'b000, 2'b00, 0, 0, 1, 5'b00000);
        // multiply contention and flush
        add_row(fu_mul, 1, 2, 8, 5'b10000, fu_n, 0, 2'b00, 3'b110, 2'b00, 0, 0, 1, 5'b00010);
        add_row(fu_alu, 1, 2, 3, 5'b10000, fu_n, 0, 2'b00, 3'b110, 2'b00, 0, 0, 0, 5'b00000);
        add_row(fu_alu, 1, 2, 3, 5'b10000, fu_n, 0, 2'b00, 3'b110, 2'b00, 0, 0, 1, 5'b10000);
        add_row(fu_mul, 1, 2, 8, 5'b10000, fu_n, 0, 2'b00, 3'b110, 2'b00, 0, 0, 1, 5'b00010);
        add_row(fu_mul, 2, 1, 9, 5'b10000, fu_n, 0, 2'b00, 3'b110, 2'b00, 0, 0, 1, 5'b00010);
        add_row(fu_mul, 1, 2, 8, 5'b10000, fu_n, 0, 2'b00, 3'b111, 2'b00, 0, 0, 1, 5'b00000);
        add_row(fu_alu, 1, 2, 3, 5'b10000, fu_n, 0, 2'b00, 3'b110, 2'b00, 0, 0, 1, 5'b10000);
        // idle, no valid instruction
        add_row(fu_alu, 1, 2, 3, 5'b00000, fu_n, 0, 2'b00, 3'b110, 2'b00, 0, 0, 0, 5'b00000);
        limit_cycles = tbl.size() * 4 + 20;

        // idle row on the inputs during reset
        drive_row(tbl.size() - 1);
        repeat (7) @(posedge clk_i);
        @(negedge clk_i);
        check_fu("fu_o", -1, fu_o, issue_pkg::NONE);
        check_data("operand_a_o", -1, operand_a_o, '0);
        check_data("operand_b_o", -1, operand_b_o, '0);
        check_data("imm_o", -1, imm_o, '0);
        check_data("pc_o", -1, pc_o, '0);
        check_data("trans_id_o", -1, issue_pkg::data_t'(trans_id_o), '0);
        check_bit("alu_valid_o", -1, alu_valid_o, 1'b0);
        check_bit("branch_valid_o", -1, branch_valid_o, 1'b0);
        check_bit("lsu_valid_o", -1, lsu_valid_o, 1'b0);
        check_bit("mult_valid_o", -1, mult_valid_o, 1'b0);
        check_bit("csr_valid_o", -1, csr_valid_o, 1'b0);
        @(posedge clk_i);
        #5;
        rst_ni = 1'b1;

        // one row per cycle, outputs of row k show up one cycle later
        for (int k = 0; k < tbl.size(); k++) begin
            if (k > 0) begin
                @(posedge clk_i);
                #5;
            end
            drive_row(k);
            expect_row(k);
            @(negedge clk_i);
            check_bit("issue_ack_o", k, issue_ack_o, tbl[k].exp_ack);
            if (k > 0) begin
                check_row(k - 1);
            end
            apply_commit(k);
        end
        @(posedge clk_i);
        @(negedge clk_i);
        check_row(tbl.size() - 1);

        $display("rows: %0d, errors: %0d", tbl.size(), errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: common/issue_cfg.svh
/*
 * issue stage configuration
 * data width, register count and commit port sizing for the integer issue path
 */
`ifndef ISSUE_CFG_SVH
`define ISSUE_CFG_SVH

// integer data path width, one machine word
`define ISSUE_XLEN 64

// architectural integer registers and their index width
`define ISSUE_NR_REGS 32
`define ISSUE_REG_ADDR_W 5

// scoreboard transaction id width
`define ISSUE_TRANS_ID_W 3

// write ports coming back from commit
`define ISSUE_NR_COMMIT 2

// zimm lives in the rs1 slot of csr instructions
`define ISSUE_ZIMM_W 5

`endif

// File: common/issue_pkg.sv
/*
 * issue stage types
 * functional unit and operator encodings, data words and commit port arrays
 */
`include "issue_cfg.svh"

package issue_pkg;

    // ------------------------------------------------------------------------
    // functional units and operators
    // ------------------------------------------------------------------------

    // unit that executes an instruction, NONE for nops and pure pass-through
    typedef enum logic [2:0] {
        NONE,
        LOAD,
        STORE,
        ALU,
        CTRL_FLOW,
        MULT,
        CSR
    } fu_t;

    // operator, only carried through to the units
    typedef enum logic [7:0] {
        ADD,
        SUB,
        AND_OP,
        OR_OP,
        SLL,
        MUL,
        BEQ,
        LD,
        SD,
        CSRRW
    } fu_op_t;

    // ------------------------------------------------------------------------
    // data and index types
    // ------------------------------------------------------------------------
    typedef logic [`ISSUE_XLEN-1:0]       data_t;
    typedef logic [`ISSUE_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`ISSUE_TRANS_ID_W-1:0] trans_id_t;

    // per register, the unit that will write it next
    typedef fu_t [`ISSUE_NR_REGS-1:0] clobber_t;

    // commit write ports
    typedef reg_addr_t [`ISSUE_NR_COMMIT-1:0] commit_addr_t;
    typedef data_t     [`ISSUE_NR_COMMIT-1:0] commit_data_t;
    typedef logic      [`ISSUE_NR_COMMIT-1:0] commit_we_t;

endpackage

// File: hw/issue/int_regfile.sv
/*
 * integer register file
 * two combinational read ports, commit write ports, x0 tied to zero
 */
`timescale 1ns/1ns
`include "issue_cfg.svh"

module int_regfile (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  issue_pkg::reg_addr_t    raddr_a_i,
    input  issue_pkg::reg_addr_t    raddr_b_i,
    output issue_pkg::data_t        rdata_a_o,
    output issue_pkg::data_t        rdata_b_o,
    input  issue_pkg::commit_addr_t waddr_i,
    input  issue_pkg::commit_data_t wdata_i,
    input  issue_pkg::commit_we_t   we_i
);

    issue_pkg::data_t regs_q [`ISSUE_NR_REGS];

    // write side
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int r = 0; r < `ISSUE_NR_REGS; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            // later ports override earlier ones on the same index
            for (int p = 0; p < `ISSUE_NR_COMMIT; p++) begin
                if (we_i[p] && waddr_i[p] != '0) begin
                    regs_q[waddr_i[p]] <= wdata_i[p];
                end
            end
        end
    end

    // read side, x0 is constant zero
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

// File: hw/issue/issue_dispatch_reg.sv
/*
 * ID/EX dispatch registers
 * operand and control registers plus one start valid per functional unit
 */
`timescale 1ns/1ns
`include "issue_cfg.svh"

module issue_dispatch_reg (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_i,
    input  logic                 issue_valid_i,
    input  logic                 issue_ack_i,
    input  logic                 issue_ex_valid_i,
    input  issue_pkg::fu_t       issue_fu_i,
    input  issue_pkg::fu_op_t    issue_op_i,
    input  issue_pkg::trans_id_t issue_trans_id_i,
    input  issue_pkg::data_t     issue_pc_i,
    input  issue_pkg::data_t     operand_a_i,
    input  issue_pkg::data_t     operand_b_i,
    input  issue_pkg::data_t     imm_i,
    output issue_pkg::data_t     operand_a_o,
    output issue_pkg::data_t     operand_b_o,
    output issue_pkg::data_t     imm_o,
    output issue_pkg::fu_t       fu_o,
    output issue_pkg::fu_op_t    operator_o,
    output issue_pkg::trans_id_t trans_id_o,
    output issue_pkg::data_t     pc_o,
    output logic                 alu_valid_o,
    output logic                 branch_valid_o,
    output logic                 lsu_valid_o,
    output logic                 mult_valid_o,
    output logic                 csr_valid_o
);

    logic start;

    // accepted and clean, a unit may be started
    assign start = issue_valid_i && issue_ack_i && !issue_ex_valid_i;

    // ------------------------------------------------------------------------
    // unit valids, one cycle pulses
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            alu_valid_o    <= 1'b0;
            branch_valid_o <= 1'b0;
            lsu_valid_o    <= 1'b0;
            mult_valid_o   <= 1'b0;
            csr_valid_o    <= 1'b0;
        end else begin
            alu_valid_o    <= start && !flush_i && issue_fu_i == issue_pkg::ALU;
            branch_valid_o <= start && !flush_i && issue_fu_i == issue_pkg::CTRL_FLOW;
            // loads and stores share the lsu
            lsu_valid_o    <= start && !flush_i && (issue_fu_i == issue_pkg::LOAD
                                                 || issue_fu_i == issue_pkg::STORE);
            mult_valid_o   <= start && !flush_i && issue_fu_i == issue_pkg::MULT;
            csr_valid_o    <= start && !flush_i && issue_fu_i == issue_pkg::CSR;
        end
    end

    // ------------------------------------------------------------------------
    // payload, loaded every cycle
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            operand_a_o <= '0;
            operand_b_o <= '0;
            imm_o       <= '0;
            fu_o        <= issue_pkg::NONE;
            operator_o  <= issue_pkg::ADD;
            trans_id_o  <= '0;
            pc_o        <= '0;
        end else begin
            operand_a_o <= operand_a_i;
            operand_b_o <= operand_b_i;
            imm_o       <= imm_i;
            fu_o        <= issue_fu_i;
            operator_o  <= issue_op_i;
            trans_id_o  <= issue_trans_id_i;
            pc_o        <= issue_pc_i;
        end
    end

endmodule

// File: hw/issue/issue_hazard_check.sv
/*
 * issue hazard check
 * operand availability, forwarding selects, unit busy, WAW and issue acknowledge
 */
`timescale 1ns/1ns
`include "issue_cfg.svh"

module issue_hazard_check (
    input  logic                    issue_valid_i,
    input  issue_pkg::fu_t          issue_fu_i,
    input  issue_pkg::reg_addr_t    issue_rs1_i,
    input  issue_pkg::reg_addr_t    issue_rs2_i,
    input  issue_pkg::reg_addr_t    issue_rd_i,
    input  logic                    issue_use_zimm_i,
    input  logic                    issue_ex_valid_i,
    input  issue_pkg::clobber_t     rd_clobber_i,
    input  logic                    rs1_valid_i,
    input  logic                    rs2_valid_i,
    input  logic                    flu_ready_i,
    input  logic                    lsu_ready_i,
    input  logic                    mult_valid_i,
    input  issue_pkg::commit_addr_t waddr_i,
    input  issue_pkg::commit_we_t   we_i,
    output logic                    fwd_rs1_o,
    output logic                    fwd_rs2_o,
    output logic                    issue_ack_o
);

    logic stall;
    logic fu_busy;
    logic rd_free;

    // ------------------------------------------------------------------------
    // source operand availability
    // ------------------------------------------------------------------------
    always_comb begin
        stall     = 1'b0;
        fwd_rs1_o = 1'b0;
        fwd_rs2_o = 1'b0;

        // zimm is an immediate, nothing to wait for on rs1
        if (!issue_use_zimm_i && rd_clobber_i[issue_rs1_i] != issue_pkg::NONE) begin
            // csr results are never forwarded, wait for the register file
            if (rs1_valid_i && rd_clobber_i[issue_rs1_i] != issue_pkg::CSR) begin
                fwd_rs1_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end

        if (rd_clobber_i[issue_rs2_i] != issue_pkg::NONE) begin
            if (rs2_valid_i && rd_clobber_i[issue_rs2_i] != issue_pkg::CSR) begin
                fwd_rs2_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
    end

    // busy signal of the unit this instruction needs
    always_comb begin
        case (issue_fu_i)
            issue_pkg::ALU, issue_pkg::CTRL_FLOW, issue_pkg::MULT, issue_pkg::CSR:
                fu_busy = ~flu_ready_i;
            issue_pkg::LOAD, issue_pkg::STORE:
                fu_busy = ~lsu_ready_i;
            default:
                fu_busy = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------------
    // WAW check and acknowledge
    // ------------------------------------------------------------------------
    always_comb begin
        // no pending writer on rd
        rd_free = (rd_clobber_i[issue_rd_i] == issue_pkg::NONE);
        // or the pending writer commits right now
        for (int i = 0; i < `ISSUE_NR_COMMIT; i++) begin
            if (we_i[i] && waddr_i[i] == issue_rd_i) begin
                rd_free = 1'b1;
            end
        end
    end

    always_comb begin
        issue_ack_o = 1'b0;
        if (issue_valid_i) begin
            if (!stall && !fu_busy && rd_free) begin
                issue_ack_o = 1'b1;
            end
            // exceptions and unit-less instructions start nothing, always take them
            if (issue_ex_valid_i || issue_fu_i == issue_pkg::NONE) begin
                issue_ack_o = 1'b1;
            end
        end
        // the multiplier result slot collides with anything but another multiply
        if (mult_valid_i && issue_fu_i != issue_pkg::MULT) begin
            issue_ack_o = 1'b0;
        end
    end

endmodule

// File: hw/issue/issue_read_operands.sv
/*
 * integer issue and read operands stage
 * hazard check, register file read, operand select and ID/EX registers
 */
`timescale 1ns/1ns
`include "issue_cfg.svh"

module issue_read_operands (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    // decoded instruction
    input  logic                    issue_valid_i,
    input  issue_pkg::fu_t          issue_fu_i,
    input  issue_pkg::fu_op_t       issue_op_i,
    input  issue_pkg::reg_addr_t    issue_rs1_i,
    input  issue_pkg::reg_addr_t    issue_rs2_i,
    input  issue_pkg::reg_addr_t    issue_rd_i,
    input  issue_pkg::data_t        issue_imm_i,
    input  issue_pkg::data_t        issue_pc_i,
    input  issue_pkg::trans_id_t    issue_trans_id_i,
    input  logic                    issue_use_imm_i,
    input  logic                    issue_use_pc_i,
    input  logic                    issue_use_zimm_i,
    input  logic                    issue_ex_valid_i,
    output logic                    issue_ack_o,
    // scoreboard
    input  issue_pkg::clobber_t     rd_clobber_i,
    input  issue_pkg::data_t        rs1_i,
    input  logic                    rs1_valid_i,
    input  issue_pkg::data_t        rs2_i,
    input  logic                    rs2_valid_i,
    // execution units
    input  logic                    flu_ready_i,
    input  logic                    lsu_ready_i,
    output issue_pkg::data_t        operand_a_o,
    output issue_pkg::data_t        operand_b_o,
    output issue_pkg::data_t        imm_o,
    output issue_pkg::fu_t          fu_o,
    output issue_pkg::fu_op_t       operator_o,
    output issue_pkg::trans_id_t    trans_id_o,
    output issue_pkg::data_t        pc_o,
    output logic                    alu_valid_o,
    output logic                    branch_valid_o,
    output logic                    lsu_valid_o,
    output logic                    mult_valid_o,
    output logic                    csr_valid_o,
    // commit
    input  issue_pkg::commit_addr_t waddr_i,
    input  issue_pkg::commit_data_t wdata_i,
    input  issue_pkg::commit_we_t   we_i
);

    logic             fwd_rs1;
    logic             fwd_rs2;
    logic             issue_ack;
    logic             mult_valid;
    issue_pkg::data_t rdata_a;
    issue_pkg::data_t rdata_b;
    issue_pkg::data_t operand_a_n;
    issue_pkg::data_t operand_b_n;
    issue_pkg::data_t imm_n;

    assign issue_ack_o  = issue_ack;
    assign mult_valid_o = mult_valid;

    issue_hazard_check u_hazard (
        .issue_valid_i    (issue_valid_i),
        .issue_fu_i       (issue_fu_i),
        .issue_rs1_i      (issue_rs1_i),
        .issue_rs2_i      (issue_rs2_i),
        .issue_rd_i       (issue_rd_i),
        .issue_use_zimm_i (issue_use_zimm_i),
        .issue_ex_valid_i (issue_ex_valid_i),
        .rd_clobber_i     (rd_clobber_i),
        .rs1_valid_i      (rs1_valid_i),
        .rs2_valid_i      (rs2_valid_i),
        .flu_ready_i      (flu_ready_i),
        .lsu_ready_i      (lsu_ready_i),
        .mult_valid_i     (mult_valid),
        .waddr_i          (waddr_i),
        .we_i             (we_i),
        .fwd_rs1_o        (fwd_rs1),
        .fwd_rs2_o        (fwd_rs2),
        .issue_ack_o      (issue_ack)
    );

    int_regfile u_regfile (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .raddr_a_i (issue_rs1_i),
        .raddr_b_i (issue_rs2_i),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b),
        .waddr_i   (waddr_i),
        .wdata_i   (wdata_i),
        .we_i      (we_i)
    );

    operand_select u_opsel (
        .rdata_a_i        (rdata_a),
        .rdata_b_i        (rdata_b),
        .rs1_i            (rs1_i),
        .rs2_i            (rs2_i),
        .fwd_rs1_i        (fwd_rs1),
        .fwd_rs2_i        (fwd_rs2),
        .issue_use_pc_i   (issue_use_pc_i),
        .issue_use_zimm_i (issue_use_zimm_i),
        .issue_use_imm_i  (issue_use_imm_i),
        .issue_fu_i       (issue_fu_i),
        .issue_rs1_i      (issue_rs1_i),
        .issue_imm_i      (issue_imm_i),
        .issue_pc_i       (issue_pc_i),
        .operand_a_o      (operand_a_n),
        .operand_b_o      (operand_b_n),
        .imm_o            (imm_n)
    );

    issue_dispatch_reg u_dispatch (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .flush_i          (flush_i),
        .issue_valid_i    (issue_valid_i),
        .issue_ack_i      (issue_ack),
        .issue_ex_valid_i (issue_ex_valid_i),
        .issue_fu_i       (issue_fu_i),
        .issue_op_i       (issue_op_i),
        .issue_trans_id_i (issue_trans_id_i),
        .issue_pc_i       (issue_pc_i),
        .operand_a_i      (operand_a_n),
        .operand_b_i      (operand_b_n),
        .imm_i            (imm_n),
        .operand_a_o      (operand_a_o),
        .operand_b_o      (operand_b_o),
        .imm_o            (imm_o),
        .fu_o             (fu_o),
        .operator_o       (operator_o),
        .trans_id_o       (trans_id_o),
        .pc_o             (pc_o),
        .alu_valid_o      (alu_valid_o),
        .branch_valid_o   (branch_valid_o),
        .lsu_valid_o      (lsu_valid_o),
        .mult_valid_o     (mult_valid),
        .csr_valid_o      (csr_valid_o)
    );

endmodule

// File: hw/issue/operand_select.sv
/*
 * operand select
 * forms operand a, operand b and imm from regfile, forwarded values and immediates
 */
`timescale 1ns/1ns
`include "issue_cfg.svh"

module operand_select (
    input  issue_pkg::data_t     rdata_a_i,
    input  issue_pkg::data_t     rdata_b_i,
    input  issue_pkg::data_t     rs1_i,
    input  issue_pkg::data_t     rs2_i,
    input  logic                 fwd_rs1_i,
    input  logic                 fwd_rs2_i,
    input  logic                 issue_use_pc_i,
    input  logic                 issue_use_zimm_i,
    input  logic                 issue_use_imm_i,
    input  issue_pkg::fu_t       issue_fu_i,
    input  issue_pkg::reg_addr_t issue_rs1_i,
    input  issue_pkg::data_t     issue_imm_i,
    input  issue_pkg::data_t     issue_pc_i,
    output issue_pkg::data_t     operand_a_o,
    output issue_pkg::data_t     operand_b_o,
    output issue_pkg::data_t     imm_o
);

    issue_pkg::data_t zimm;

    // zero extended rs1 index
    assign zimm = {{(`ISSUE_XLEN-`ISSUE_ZIMM_W){1'b0}}, issue_rs1_i[`ISSUE_ZIMM_W-1:0]};

    // operand a, zimm over pc over forwarded over regfile
    always_comb begin
        if (issue_use_zimm_i) begin
            operand_a_o = zimm;
        end else if (issue_use_pc_i) begin
            operand_a_o = issue_pc_i;
        end else if (fwd_rs1_i) begin
            operand_a_o = rs1_i;
        end else begin
            operand_a_o = rdata_a_i;
        end
    end

    // operand b
    always_comb begin
        operand_b_o = fwd_rs2_i ? rs2_i : rdata_b_i;
        // stores keep rs2 as data, branches compare rs1 and rs2
        if (issue_use_imm_i && issue_fu_i != issue_pkg::STORE
                && issue_fu_i != issue_pkg::CTRL_FLOW) begin
            operand_b_o = issue_imm_i;
        end
    end

    // address offset or branch target always rides on imm
    assign imm_o = issue_imm_i;

endmodule

// File: tb.f
+incdir+common
common/issue_pkg.sv
hw/issue/issue_hazard_check.sv
hw/issue/int_regfile.sv
hw/issue/operand_select.sv
hw/issue/issue_dispatch_reg.sv
hw/issue/issue_read_operands.sv
bench/tb_issue_read_operands.sv
